/* all.f */
+incdir+src
src/ciExtPkg.sv
src/ciUnitIf.sv
src/resetSequencer.sv
src/ciDispatch.sv
src/swapByteUnit.sv
src/grayscaleUnit.sv
src/delayUnit.sv
src/profileUnit.sv
src/ciExtensionTop.sv
verification/ciExtensionTb.sv

/* verification/ciExtensionTb.sv */
`include "ciExt_config.svh"

module ciExtensionTb import ciExtPkg::*; ();

  localparam int resetBudget  = 20;
  localparam int releaseDelay = 1 << (`CI_RESET_COUNT_WIDTH - 1);

  logic      s_systemClock;
  logic      s_pllLocked;
  logic      ciStart;
  ciNumber_t ciN;
  ciWord_t   ciDataA;
  ciWord_t   ciDataB;
  logic      ciDone;
  ciWord_t   ciResult;
  logic      peripheralResetN;

  // shadow of the profiler state, advanced once per cycle.
  ciWord_t shadowCycles;
  ciWord_t shadowInstructions;
  ciWord_t shadowStalls;
  logic    shadowEnabled;
  int      busyLeft;

  int      issuedCount;
  int      completedCount;
  int      latencyBudget;
  ciWord_t lastResult;

  ciExtensionTop UUT (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .ciStart          (ciStart),
    .ciN              (ciN),
    .ciDataA          (ciDataA),
    .ciDataB          (ciDataB),
    .ciDone           (ciDone),
    .ciResult         (ciResult),
    .peripheralResetN (peripheralResetN)
  );

  always #2 s_systemClock = ~s_systemClock;

  task automatic stopRun();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkWord(input string name, input ciWord_t actual, input ciWord_t expected);
    if (actual !== expected) begin
      $display("MISMATCH %s expected 0x%08h got 0x%08h", name, expected, actual);
      stopRun();
    end
  endtask

  task automatic checkLatency(input string name, input int actual, input int expected);
    if (actual != expected) begin
      $display("MISMATCH %s expected 0x%0h got 0x%0h", name, expected, actual);
      stopRun();
    end
  endtask

  // a zero count still occupies one cycle.
  function automatic int delayLatency(input ciWord_t a);
    int count;
    int cyclesNeeded;
    count        = a[`CI_DELAY_WIDTH-1:0];
    cyclesNeeded = count * `CI_TICKS_PER_MICRO;
    if (cyclesNeeded < 1) begin
      cyclesNeeded = 1;
    end
    return cyclesNeeded;
  endfunction

  function automatic int expectedLatency(input ciNumber_t n, input ciWord_t a);
    return (n == delay) ? delayLatency(a) : 0;
  endfunction

  function automatic ciWord_t grayModel(input logic [15:0] pixel);
    int r;
    int g;
    int b;
    r = pixel[15:11];
    g = pixel[10:5];
    b = pixel[4:0];
    r = r * 8 + r / 4;
    g = g * 4 + g / 16;
    b = b * 8 + b / 4;
    return ciWord_t'((r * 77 + g * 150 + b * 29) / 256);
  endfunction

  function automatic ciWord_t ciModel(input ciNumber_t n, input ciWord_t a, input ciWord_t b);
    ciWord_t res;
    int      i;
    res = '0;
    case (n)
      swapByte: begin
        for (i = 0; i < 4; i++) begin
          if (b[0]) begin
            res[8*i +: 8] = a[8*(i ^ 1) +: 8];
          end else begin
            res[8*i +: 8] = a[8*(3 - i) +: 8];
          end
        end
      end
      grayscale: res = grayModel(a[15:0]);
      profile: begin
        case (a[1:0])
          2'd0:    res = shadowCycles;
          2'd1:    res = shadowInstructions;
          2'd2:    res = shadowStalls;
          default: res = '0;
        endcase
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  task automatic advanceShadow(input logic start, input ciNumber_t n, input ciWord_t a,
                               input ciWord_t b);
    logic stallNow;
    stallNow = (busyLeft > 0);
    if (start && n == profile && b[2]) begin
      shadowCycles       = '0;
      shadowInstructions = '0;
      shadowStalls       = '0;
    end else if (shadowEnabled) begin
      shadowCycles = shadowCycles + 1;
      if (start) begin
        shadowInstructions = shadowInstructions + 1;
      end
      if (stallNow) begin
        shadowStalls = shadowStalls + 1;
      end
    end
    if (start && n == profile) begin
      if (b[1]) begin
        shadowEnabled = 1'b0;
      end else if (b[0]) begin
        shadowEnabled = 1'b1;
      end
    end
    if (stallNow) begin
      busyLeft--;
    end
    if (start && n == delay) begin
      busyLeft = delayLatency(a);
    end
  endtask

  // one-cycle start pulse, then hold off until the checker has seen done.
  task automatic issueInstruction(input ciNumber_t n, input ciWord_t a, input ciWord_t b);
    ciStart = 1'b1;
    ciN     = n;
    ciDataA = a;
    ciDataB = b;
    issuedCount++;
    latencyBudget += expectedLatency(n, a) + 1;
    @(posedge s_systemClock);
    #1;
    ciStart = 1'b0;
    while (completedCount != issuedCount) begin
      @(posedge s_systemClock);
      #1;
    end
  endtask

  task automatic byteSwapSequence();
    ciWord_t mode;
    int      i;
    for (i = 0; i < 50; i++) begin
      mode    = $urandom;
      mode[0] = i[0];
      issueInstruction(swapByte, $urandom, mode);
    end
  endtask

  task automatic grayscaleSequence();
    int i;
    issueInstruction(grayscale, 32'h0000_0000, 32'h0);
    checkWord("gray of black pixel", lastResult, 32'd0);
    issueInstruction(grayscale, 32'h0000_ffff, 32'h0);
    checkWord("gray of white pixel", lastResult, 32'd255);
    for (i = 0; i < 50; i++) begin
      issueInstruction(grayscale, $urandom, $urandom);
    end
  endtask

  task automatic delaySequence();
    int i;
    issueInstruction(delay, 32'd0, $urandom);
    issueInstruction(delay, 32'd1, 32'h0);
    // upper operand bits are noise the unit has to ignore.
    for (i = 0; i < 8; i++) begin
      issueInstruction(delay, {16'($urandom), 16'($urandom % 21)}, 32'h0);
    end
  endtask

  task automatic profilingSequence();
    int i;
    int stallSum;
    stallSum = 2 * `CI_TICKS_PER_MICRO + 1 + 3 * `CI_TICKS_PER_MICRO;
    issueInstruction(profile, 32'd0, 32'h1);
    issueInstruction(swapByte, 32'h1122_3344, 32'h0);
    issueInstruction(grayscale, 32'h0000_f81f, 32'h0);
    issueInstruction(delay, 32'd2, 32'h0);
    issueInstruction(delay, 32'd0, 32'h0);
    issueInstruction(ciNumber_t'(9), 32'h0, 32'h0);
    issueInstruction(delay, 32'd3, 32'h0);
    issueInstruction(profile, 32'(cycles), 32'h0);
    issueInstruction(profile, 32'(instructions), 32'h0);
    checkWord("instruction counter", lastResult, 32'd7);
    // stall read also turns counting off.
    issueInstruction(profile, 32'(stalls), 32'h2);
    checkWord("stall counter", lastResult, ciWord_t'(stallSum));
    issueInstruction(profile, 32'(cycles), 32'h4);
    for (i = 0; i < 3; i++) begin
      issueInstruction(profile, ciWord_t'(i), 32'h0);
      checkWord("counter after clear", lastResult, 32'd0);
    end
  endtask

  task automatic unknownOpcodeSequence();
    issueInstruction(ciNumber_t'(9), $urandom, $urandom);
    issueInstruction(ciNumber_t'(0), $urandom, $urandom);
    issueInstruction(ciNumber_t'(255), $urandom, $urandom);
  endtask

  initial begin : mainSequence
    int releaseCycles;
    s_systemClock      = 1'b0;
    s_pllLocked        = 1'b0;
    ciStart            = 1'b0;
    ciN                = '0;
    ciDataA            = '0;
    ciDataB            = '0;
    shadowCycles       = '0;
    shadowInstructions = '0;
    shadowStalls       = '0;
    shadowEnabled      = 1'b0;
    busyLeft           = 0;
    issuedCount        = 0;
    completedCount     = 0;
    latencyBudget      = resetBudget;
    lastResult         = '0;
    void'($urandom(32'hdb33));
    repeat (2) @(posedge s_systemClock);
    #1;
    s_pllLocked   = 1'b1;
    releaseCycles = 0;
    @(negedge s_systemClock);
    while (peripheralResetN !== 1'b1) begin
      if (ciDone !== 1'b0) begin
        $display("ciDone was not low while the units were held in reset");
        stopRun();
      end
      releaseCycles++;
      @(negedge s_systemClock);
    end
    checkLatency("peripheralResetN release", releaseCycles, releaseDelay);
    @(posedge s_systemClock);
    #1;
    byteSwapSequence();
    grayscaleSequence();
    delaySequence();
    profilingSequence();
    unknownOpcodeSequence();
    repeat (4) @(posedge s_systemClock);
    $display("TESTBENCH PASSED");
    $finish;
  end

  // samples mid-cycle, where inputs and combinational outputs have settled.
  initial begin : compareProcess
    logic    outstanding;
    int      elapsed;
    int      expLatency;
    ciWord_t expResult;
    outstanding = 1'b0;
    elapsed     = 0;
    expLatency  = 0;
    expResult   = '0;
    wait (peripheralResetN === 1'b1);
    forever begin
      @(negedge s_systemClock);
      if (ciStart) begin
        if (outstanding) begin
          $display("ciStart arrived before the previous instruction was done");
          stopRun();
        end
        expResult   = ciModel(ciN, ciDataA, ciDataB);
        expLatency  = expectedLatency(ciN, ciDataA);
        outstanding = 1'b1;
        elapsed     = 0;
      end
      if (ciDone === 1'b1) begin
        if (!outstanding) begin
          $display("ciDone rose with no instruction outstanding");
          stopRun();
        end
        checkLatency("ciDone latency", elapsed, expLatency);
        checkWord("ciResult", ciResult, expResult);
        lastResult  = ciResult;
        outstanding = 1'b0;
        completedCount++;
      end else begin
        checkWord("ciResult while idle", ciResult, '0);
        if (outstanding && elapsed >= expLatency) begin
          $display("ciDone did not rise %0d cycles after start", expLatency);
          stopRun();
        end
      end
      advanceShadow(ciStart, ciN, ciDataA, ciDataB);
      if (outstanding) begin
        elapsed++;
      end
    end
  end

  // limit grows with every issued instruction.
  initial begin : watchdog
    int cycleCounter;
    cycleCounter = 0;
    while (cycleCounter <= 2 * latencyBudget + 100) begin
      @(posedge s_systemClock);
      cycleCounter++;
    end
    $display("timeout after %0d cycles, the instruction sequence did not finish", cycleCounter);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

endmodule

/* src/ciExtensionTop.sv */
module ciExtensionTop import ciExtPkg::*; (
  input  logic      s_systemClock,
  input  logic      s_pllLocked,
  input  logic      ciStart,
  input  ciNumber_t ciN,
  input  ciWord_t   ciDataA,
  input  ciWord_t   ciDataB,
  output logic      ciDone,
  output ciWord_t   ciResult,
  output logic      peripheralResetN
);

  logic unitReset;
  logic delayBusy;

  ciUnitIf swapIf ();
  ciUnitIf grayIf ();
  ciUnitIf delayIf ();
  ciUnitIf profileIf ();

  resetSequencer resetSeq (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .unitReset        (unitReset),
    .peripheralResetN (peripheralResetN)
  );

  ciDispatch dispatcher (
    .s_systemClock (s_systemClock),
    .unitReset     (unitReset),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .ciDone        (ciDone),
    .ciResult      (ciResult),
    .swapPort      (swapIf.dispatch),
    .grayPort      (grayIf.dispatch),
    .delayPort     (delayIf.dispatch),
    .profilePort   (profileIf.dispatch)
  );

  swapByteUnit swapUnit (
    .unitPort (swapIf.unit)
  );

  grayscaleUnit grayUnit (
    .unitPort (grayIf.unit)
  );

  delayUnit microDelay (
    .s_systemClock (s_systemClock),
    .unitReset     (unitReset),
    .unitPort      (delayIf.unit),
    .busy          (delayBusy)
  );

  // the processor is stalled for as long as the delay unit is busy.
  profileUnit profiler (
    .s_systemClock    (s_systemClock),
    .unitReset        (unitReset),
    .unitPort         (profileIf.unit),
    .instructionEvent (ciStart),
    .stallEvent       (delayBusy)
  );

endmodule

/* src/profileUnit.sv */
module profileUnit import ciExtPkg::*; (
  input  logic  s_systemClock,
  input  logic  unitReset,
  ciUnitIf.unit unitPort,
  input  logic  instructionEvent,
  input  logic  stallEvent
);

  ciWord_t        cycleCount;
  ciWord_t        instructionCount;
  ciWord_t        stallCount;
  logic           enabled;
  logic           clearAll;
  profileSelect_t counterSelect;
  ciWord_t        selectedCount;

  assign counterSelect = profileSelect_t'(unitPort.dataA[1:0]);
  assign clearAll      = unitPort.start && unitPort.dataB[2];

  // disable wins when both control bits are set.
  always_ff @(posedge s_systemClock or posedge unitReset) begin
    if (unitReset) begin
      enabled <= 1'b0;
    end else if (unitPort.start && unitPort.dataB[1]) begin
      enabled <= 1'b0;
    end else if (unitPort.start && unitPort.dataB[0]) begin
      enabled <= 1'b1;
    end
  end

  // counting in the start cycle still uses the old enable.
  always_ff @(posedge s_systemClock or posedge unitReset) begin
    if (unitReset) begin
      cycleCount       <= '0;
      instructionCount <= '0;
      stallCount       <= '0;
    end else if (clearAll) begin
      cycleCount       <= '0;
      instructionCount <= '0;
      stallCount       <= '0;
    end else if (enabled) begin
      cycleCount <= cycleCount + 1'b1;
      if (instructionEvent) begin
        instructionCount <= instructionCount + 1'b1;
      end
      if (stallEvent) begin
        stallCount <= stallCount + 1'b1;
      end
    end
  end

  always_comb begin
    case (counterSelect)
      cycles:       selectedCount = cycleCount;
      instructions: selectedCount = instructionCount;
      stalls:       selectedCount = stallCount;
      default:      selectedCount = '0;
    endcase
  end

  // the read returns the value from before this cycle's update.
  assign unitPort.done   = unitPort.start;
  assign unitPort.result = unitPort.start ? selectedCount : '0;

endmodule

/* src/delayUnit.sv */
`include "ciExt_config.svh"

module delayUnit import ciExtPkg::*; (
  input  logic  s_systemClock,
  input  logic  unitReset,
  ciUnitIf.unit unitPort,
  output logic  busy
);

  localparam int tickWidth = $clog2(`CI_TICKS_PER_MICRO + 1);
  localparam logic [tickWidth-1:0] lastTick = tickWidth'(`CI_TICKS_PER_MICRO - 1);

  typedef enum logic {
    delayIdle,
    delayWaiting
  } delayState_t;

  delayState_t                state;
  logic [`CI_DELAY_WIDTH-1:0] microRemaining;
  logic [tickWidth-1:0]       tickCount;
  logic                       finishing;

  // a zero count still takes one cycle.
  assign finishing = (microRemaining == '0) ||
                     (microRemaining == `CI_DELAY_WIDTH'(1) && tickCount == lastTick);

  always_ff @(posedge s_systemClock or posedge unitReset) begin
    if (unitReset) begin
      state          <= delayIdle;
      microRemaining <= '0;
      tickCount      <= '0;
    end else begin
      case (state)
        delayIdle: begin
          if (unitPort.start) begin
            state          <= delayWaiting;
            microRemaining <= unitPort.dataA[`CI_DELAY_WIDTH-1:0];
            tickCount      <= '0;
          end
        end
        delayWaiting: begin
          if (finishing) begin
            state <= delayIdle;
          end else if (tickCount == lastTick) begin
            // one microsecond elapsed.
            tickCount      <= '0;
            microRemaining <= microRemaining - 1'b1;
          end else begin
            tickCount <= tickCount + 1'b1;
          end
        end
        default: state <= delayIdle;
      endcase
    end
  end

  assign busy            = (state == delayWaiting);
  assign unitPort.done   = busy && finishing;
  assign unitPort.result = ciWord_t'(0);

  // a start during the wait would be dropped by the FSM.
  assert property (@(posedge s_systemClock) disable iff (unitReset)
    unitPort.start |-> !busy);

endmodule

/* src/grayscaleUnit.sv */
module grayscaleUnit import ciExtPkg::*; (
  ciUnitIf.unit unitPort
);

  logic [4:0]  red5;
  logic [5:0]  green6;
  logic [4:0]  blue5;
  logic [7:0]  red8;
  logic [7:0]  green8;
  logic [7:0]  blue8;
  logic [15:0] weightedSum;
  logic [7:0]  gray;

  assign red5   = unitPort.dataA[15:11];
  assign green6 = unitPort.dataA[10:5];
  assign blue5  = unitPort.dataA[4:0];

  // repeat the top bits so full scale maps to 255.
  assign red8   = {red5, red5[4:2]};
  assign green8 = {green6, green6[5:4]};
  assign blue8  = {blue5, blue5[4:2]};

  // weights sum to 256, the high byte is the luminance.
  assign weightedSum = red8 * 16'd77 + green8 * 16'd150 + blue8 * 16'd29;
  assign gray        = weightedSum[15:8];

  assign unitPort.done   = unitPort.start;
  assign unitPort.result = unitPort.start ? ciWord_t'(gray) : '0;

endmodule

/* src/swapByteUnit.sv */
module swapByteUnit import ciExtPkg::*; (
  ciUnitIf.unit unitPort
);

  ciWord_t reversed;
  ciWord_t halfSwapped;

  // full reversal, byte 3 ends up in byte 0.
  assign reversed = {unitPort.dataA[7:0],
                     unitPort.dataA[15:8],
                     unitPort.dataA[23:16],
                     unitPort.dataA[31:24]};

  // bytes exchanged inside each 16-bit half.
  assign halfSwapped = {unitPort.dataA[23:16],
                        unitPort.dataA[31:24],
                        unitPort.dataA[7:0],
                        unitPort.dataA[15:8]};

  assign unitPort.done = unitPort.start;

  always_comb begin
    if (!unitPort.start) begin
      unitPort.result = '0;
    end else if (unitPort.dataB[0]) begin
      unitPort.result = halfSwapped;
    end else begin
      unitPort.result = reversed;
    end
  end

endmodule

/* src/ciDispatch.sv */
module ciDispatch import ciExtPkg::*; (
  input  logic      s_systemClock,
  input  logic      unitReset,
  input  logic      ciStart,
  input  ciNumber_t ciN,
  input  ciWord_t   ciDataA,
  input  ciWord_t   ciDataB,
  output logic      ciDone,
  output ciWord_t   ciResult,
  ciUnitIf.dispatch swapPort,
  ciUnitIf.dispatch grayPort,
  ciUnitIf.dispatch delayPort,
  ciUnitIf.dispatch profilePort
);

  ciOpcode_t opcode;
  logic      unknownDone;

  assign opcode = ciOpcode_t'(ciN);

  // start goes to exactly one unit; an unmatched number answers itself.
  always_comb begin
    swapPort.start    = 1'b0;
    grayPort.start    = 1'b0;
    delayPort.start   = 1'b0;
    profilePort.start = 1'b0;
    unknownDone       = 1'b0;
    case (opcode)
      swapByte:  swapPort.start    = ciStart;
      grayscale: grayPort.start    = ciStart;
      delay:     delayPort.start   = ciStart;
      profile:   profilePort.start = ciStart;
      default:   unknownDone       = ciStart;
    endcase
  end

  assign swapPort.dataA    = ciDataA;
  assign swapPort.dataB    = ciDataB;
  assign grayPort.dataA    = ciDataA;
  assign grayPort.dataB    = ciDataB;
  assign delayPort.dataA   = ciDataA;
  assign delayPort.dataB   = ciDataB;
  assign profilePort.dataA = ciDataA;
  assign profilePort.dataB = ciDataB;

  // units keep their result at zero unless done, so a plain OR merges them.
  assign ciDone = swapPort.done | grayPort.done | delayPort.done | profilePort.done |
                  unknownDone;
  assign ciResult = swapPort.result | grayPort.result | delayPort.result |
                    profilePort.result;

  // two units answering in the same cycle would corrupt the merged result.
  assert property (@(posedge s_systemClock) disable iff (unitReset)
    $onehot0({swapPort.done, grayPort.done, delayPort.done, profilePort.done, unknownDone}));

  // the processor stalls until done, so no start may overlap an open instruction.
  assert property (@(posedge s_systemClock) disable iff (unitReset)
    (ciStart && !ciDone) |=> (!ciStart until_with ciDone));

endmodule

/* src/resetSequencer.sv */
`include "ciExt_config.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic unitReset,
  output logic peripheralResetN
);

  localparam int topBit = `CI_RESET_COUNT_WIDTH - 1;

  logic [`CI_RESET_COUNT_WIDTH-1:0] resetCount;

  // counts up after lock and parks once the top bit is set.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[topBit]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign peripheralResetN = resetCount[topBit];
  assign unitReset        = ~resetCount[topBit];

endmodule

/* src/ciUnitIf.sv */
interface ciUnitIf;

  logic             start;
  ciExtPkg::ciWord_t dataA;
  ciExtPkg::ciWord_t dataB;
  logic             done;
  ciExtPkg::ciWord_t result;

  // dispatcher side.
  modport dispatch (
    output start, dataA, dataB,
    input  done, result
  );

  // extension unit side.
  modport unit (
    input  start, dataA, dataB,
    output done, result
  );

endinterface

/* src/ciExtPkg.sv */
`include "ciExt_config.svh"

package ciExtPkg;

  typedef logic [`CI_DATA_WIDTH-1:0] ciWord_t;
  typedef logic [`CI_N_WIDTH-1:0] ciNumber_t;

  // instruction numbers decoded by the dispatcher.
  typedef enum logic [`CI_N_WIDTH-1:0] {
    swapByte  = `CI_OP_SWAP,
    delay     = `CI_OP_DELAY,
    profile   = `CI_OP_PROFILE,
    grayscale = `CI_OP_GRAY
  } ciOpcode_t;

  // counter read back by the profiler, taken from operand A bits 1:0.
  typedef enum logic [1:0] {
    cycles       = 2'd0,
    instructions = 2'd1,
    stalls       = 2'd2
  } profileSelect_t;

endpackage

/* src/ciExt_config.svh */
`ifndef CI_EXT_CONFIG_SVH
`define CI_EXT_CONFIG_SVH

// operand, result and instruction-number widths.
`define CI_DATA_WIDTH 32
`define CI_N_WIDTH 8

// custom-instruction numbers as seen on ciN.
`define CI_OP_SWAP 1
`define CI_OP_DELAY 6
`define CI_OP_PROFILE 11
`define CI_OP_GRAY 12

// system-clock cycles in one microsecond.
`define CI_TICKS_PER_MICRO 5

// low bits of operand A that hold the delay in microseconds.
`define CI_DELAY_WIDTH 16

// top bit of this counter releases the unit reset.
`define CI_RESET_COUNT_WIDTH 5

`endif
